// File: hdl/div_pkg.sv
`default_nettype none

package div_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] data_t;
    typedef logic [4:0] reg_addr_t;

    // A position of 0 marks a zero value, p marks bit p-1 as the highest one.
    typedef logic [5:0] bit_pos_t;
    typedef logic [5:0] step_cnt_t;

    typedef struct packed {
        logic      rem_sel;
        logic      is_signed;
        data_t     dividend;
        data_t     divisor;
        reg_addr_t addr;
    } div_req_t;

    typedef struct packed {
        data_t     result;
        reg_addr_t addr;
    } div_resp_t;

    typedef enum logic [1:0] {
        idle,
        iterate,
        finish
    } div_state_t;

endpackage

`default_nettype wire

// File: hdl/div_operand_prep.sv
`timescale 1ns/10ps
`default_nettype none

module div_operand_prep (
    input  wire div_pkg::div_req_t req,
    output div_pkg::data_t         abs_dividend,
    output div_pkg::data_t         abs_divisor,
    output logic                   dividend_neg,
    output logic                   divisor_neg,
    output div_pkg::bit_pos_t      dividend_pos,
    output div_pkg::bit_pos_t      divisor_pos
);

    // Highest set bit, counted from 1, so that zero maps to position 0.
    function automatic div_pkg::bit_pos_t lead_one_pos(input div_pkg::data_t value);
        div_pkg::bit_pos_t pos;
        pos = '0;
        for (int i = 0; i < div_pkg::xlen; i++) begin
            if (value[i]) begin
                pos = div_pkg::bit_pos_t'(i + 1);
            end
        end
        return pos;
    endfunction

    assign dividend_neg = req.is_signed && req.dividend[div_pkg::xlen-1];
    assign divisor_neg  = req.is_signed && req.divisor[div_pkg::xlen-1];

    // The most negative value negates to itself, which reads correctly as an unsigned magnitude.
    assign abs_dividend = dividend_neg ? (~req.dividend + 1'b1) : req.dividend;
    assign abs_divisor  = divisor_neg ? (~req.divisor + 1'b1) : req.divisor;

    assign dividend_pos = lead_one_pos(abs_dividend);
    assign divisor_pos  = lead_one_pos(abs_divisor);

endmodule

`default_nettype wire

// File: hdl/div_control.sv
`timescale 1ns/10ps
`default_nettype none

module div_control (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    div_en_in,
    input  wire div_pkg::bit_pos_t dividend_pos,
    input  wire div_pkg::bit_pos_t divisor_pos,
    output logic                   load,
    output logic                   load_trivial,
    output div_pkg::bit_pos_t      shift_amt,
    output logic                   step,
    output logic                   done,
    output logic                   stall_because_div
);

    div_pkg::div_state_t state_q;
    div_pkg::step_cnt_t  cnt_q;
    div_pkg::bit_pos_t   pos_diff;
    logic                trivial;

    // A zero divisor or a smaller dividend gives a zero quotient without any steps.
    assign trivial  = (divisor_pos == '0) || (dividend_pos < divisor_pos);
    assign pos_diff = dividend_pos - divisor_pos;

    assign load              = (state_q == div_pkg::idle) && div_en_in;
    assign load_trivial      = load && trivial;
    assign shift_amt         = trivial ? '0 : pos_diff;
    assign step              = (state_q == div_pkg::iterate);
    assign done              = (state_q == div_pkg::finish);
    assign stall_because_div = (state_q != div_pkg::idle);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= div_pkg::idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                div_pkg::idle: begin
                    if (div_en_in) begin
                        if (trivial) begin
                            state_q <= div_pkg::finish;
                            cnt_q   <= '0;
                        end else begin
                            // One step per quotient bit, k+1 bits in all.
                            state_q <= div_pkg::iterate;
                            cnt_q   <= div_pkg::step_cnt_t'(pos_diff) + 1'b1;
                        end
                    end
                end
                div_pkg::iterate: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == div_pkg::step_cnt_t'(1)) begin
                        state_q <= div_pkg::finish;
                    end
                end
                div_pkg::finish: begin
                    state_q <= div_pkg::idle;
                end
                default: begin
                    state_q <= div_pkg::idle;
                end
            endcase
        end
    end

    // A running loop always has at least one step left.
    step_cnt_live: assert property (@(posedge clk) disable iff (!rstn)
        step |-> (cnt_q != '0));

    cnt_in_range: assert property (@(posedge clk) disable iff (!rstn)
        load |=> (cnt_q <= div_pkg::xlen));

endmodule

`default_nettype wire

// File: hdl/div_shift_subtract.sv
`timescale 1ns/10ps
`default_nettype none

module div_shift_subtract (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    load,
    input  wire                    load_trivial,
    input  wire                    step,
    input  wire div_pkg::bit_pos_t shift_amt,
    input  wire div_pkg::data_t    abs_dividend,
    input  wire div_pkg::data_t    abs_divisor,
    output div_pkg::data_t         quotient,
    output div_pkg::data_t         remainder
);

    localparam int dw = 2 * div_pkg::xlen;

    div_pkg::data_t rem_q;
    div_pkg::data_t quo_q;
    logic [dw-1:0]  dsr_q;
    logic           fits;

    // The shifted divisor is aligned to the dividend's leading one on load.
    assign fits = {{div_pkg::xlen{1'b0}}, rem_q} >= dsr_q;

    always_ff @(posedge clk) begin
        if (load) begin
            rem_q <= abs_dividend;
            quo_q <= '0;
            if (load_trivial) begin
                dsr_q <= '0;
            end else begin
                dsr_q <= {{div_pkg::xlen{1'b0}}, abs_divisor} << shift_amt;
            end
        end else if (step) begin
            if (fits) begin
                rem_q <= rem_q - dsr_q[div_pkg::xlen-1:0];
            end
            quo_q <= {quo_q[div_pkg::xlen-2:0], fits};
            dsr_q <= dsr_q >> 1;
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

    // Each step leaves less than the divisor it tried, which holds only if the load aligned it.
    rem_step_bounds: assert property (@(posedge clk) disable iff (!rstn)
        step |=> (rem_q <= $past(rem_q)) && (rem_q < $past(dsr_q)));

endmodule

`default_nettype wire

// File: hdl/div_result_fix.sv
`timescale 1ns/10ps
`default_nettype none

module div_result_fix (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    load,
    input  wire                    done,
    input  wire div_pkg::div_req_t req,
    input  wire                    dividend_neg,
    input  wire                    divisor_neg,
    input  wire div_pkg::data_t    quotient,
    input  wire div_pkg::data_t    remainder,
    output logic                   div_en_out,
    output div_pkg::div_resp_t     div_resp
);

    logic                  rem_sel_q;
    logic                  dividend_neg_q;
    logic                  divisor_neg_q;
    div_pkg::reg_addr_t    addr_q;
    div_pkg::data_t        result;

    always_ff @(posedge clk) begin
        if (load) begin
            rem_sel_q      <= req.rem_sel;
            addr_q         <= req.addr;
            dividend_neg_q <= dividend_neg;
            divisor_neg_q  <= divisor_neg;
        end
    end

    // The remainder follows the dividend's sign, the quotient the sign of the product.
    always_comb begin
        if (rem_sel_q) begin
            result = dividend_neg_q ? (~remainder + 1'b1) : remainder;
        end else begin
            result = (dividend_neg_q ^ divisor_neg_q) ? (~quotient + 1'b1) : quotient;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            div_en_out <= 1'b0;
            div_resp   <= '0;
        end else begin
            div_en_out <= done;
            if (done) begin
                div_resp.result <= result;
                div_resp.addr   <= addr_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
`timescale 1ns/10ps
`default_nettype none

module div_unit (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    div_en_in,
    input  wire div_pkg::div_req_t div_req,
    output logic                   div_en_out,
    output div_pkg::div_resp_t     div_resp,
    output logic                   stall_because_div
);

    div_pkg::data_t    abs_dividend;
    div_pkg::data_t    abs_divisor;
    logic              dividend_neg;
    logic              divisor_neg;
    div_pkg::bit_pos_t dividend_pos;
    div_pkg::bit_pos_t divisor_pos;
    logic              load;
    logic              load_trivial;
    div_pkg::bit_pos_t shift_amt;
    logic              step;
    logic              done;
    div_pkg::data_t    quotient;
    div_pkg::data_t    remainder;

    div_operand_prep prep_i (
        .req          (div_req),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .dividend_neg (dividend_neg),
        .divisor_neg  (divisor_neg),
        .dividend_pos (dividend_pos),
        .divisor_pos  (divisor_pos)
    );

    div_control control_i (
        .clk               (clk),
        .rstn              (rstn),
        .div_en_in         (div_en_in),
        .dividend_pos      (dividend_pos),
        .divisor_pos       (divisor_pos),
        .load              (load),
        .load_trivial      (load_trivial),
        .shift_amt         (shift_amt),
        .step              (step),
        .done              (done),
        .stall_because_div (stall_because_div)
    );

    div_shift_subtract datapath_i (
        .clk          (clk),
        .rstn         (rstn),
        .load         (load),
        .load_trivial (load_trivial),
        .step         (step),
        .shift_amt    (shift_amt),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .quotient     (quotient),
        .remainder    (remainder)
    );

    div_result_fix fix_i (
        .clk          (clk),
        .rstn         (rstn),
        .load         (load),
        .done         (done),
        .req          (div_req),
        .dividend_neg (dividend_neg),
        .divisor_neg  (divisor_neg),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_en_out   (div_en_out),
        .div_resp     (div_resp)
    );

endmodule

`default_nettype wire

// File: test/div_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module div_unit_tb;

    logic               clk;
    logic               rstn;
    logic               div_en_in;
    div_pkg::div_req_t  div_req;
    logic               div_en_out;
    div_pkg::div_resp_t div_resp;
    logic               stall_because_div;

    integer             seed;
    string              test_name;
    int                 err_cnt;
    int                 req_cnt;
    int                 test_cnt;
    int                 test_err_base;
    int                 test_req_base;

    // Expected response of the division in flight, captured when the DUT accepts it.
    logic               in_flight;
    logic               got_result;
    int                 edge_cnt;
    int                 exp_lat;
    div_pkg::data_t     exp_result;
    div_pkg::reg_addr_t exp_addr;

    div_unit div_unit_i (
        .clk               (clk),
        .rstn              (rstn),
        .div_en_in         (div_en_in),
        .div_req           (div_req),
        .div_en_out        (div_en_out),
        .div_resp          (div_resp),
        .stall_because_div (stall_because_div)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Truncating division done in 64 bits, so the most negative value over -1 cannot overflow.
    function automatic div_pkg::data_t expect_result(input div_pkg::div_req_t r);
        logic signed [63:0] a;
        logic signed [63:0] b;
        logic signed [63:0] q;
        logic signed [63:0] m;
        a = r.is_signed ? {{32{r.dividend[31]}}, r.dividend} : {32'd0, r.dividend};
        b = r.is_signed ? {{32{r.divisor[31]}}, r.divisor} : {32'd0, r.divisor};
        if (b == 0) begin
            q = 0;
            m = a;
        end else begin
            q = a / b;
            m = a % b;
        end
        return r.rem_sel ? m[31:0] : q[31:0];
    endfunction

    function automatic div_pkg::data_t magnitude(input div_pkg::data_t v, input logic sgn);
        return (sgn && v[31]) ? -v : v;
    endfunction

    function automatic int top_bit(input div_pkg::data_t v);
        int p;
        p = 32;
        while (p > 0 && !v[p-1]) begin
            p--;
        end
        return p;
    endfunction

    function automatic int expect_latency(input div_pkg::div_req_t r);
        int pa;
        int pb;
        pa = top_bit(magnitude(r.dividend, r.is_signed));
        pb = top_bit(magnitude(r.divisor, r.is_signed));
        return (pb == 0 || pa < pb) ? 2 : pa - pb + 3;
    endfunction

    always @(posedge clk) begin
        if (!rstn) begin
            in_flight  <= 1'b0;
            got_result <= 1'b0;
            edge_cnt   <= 0;
        end else begin
            if (div_en_out) begin
                got_result <= 1'b1;
            end
            if (div_en_in && !stall_because_div) begin
                exp_result <= expect_result(div_req);
                exp_addr   <= div_req.addr;
                exp_lat    <= expect_latency(div_req);
                edge_cnt   <= 1;
                in_flight  <= 1'b1;
            end else if (in_flight) begin
                edge_cnt <= edge_cnt + 1;
                if (div_en_out) begin
                    in_flight <= 1'b0;
                end
            end
        end
    end

    result_matches: assert property (@(posedge clk) disable iff (!rstn)
        div_en_out |-> (div_resp.result == exp_result))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %s: result expected %08h actual %08h", test_name, exp_result,
                     div_resp.result);
        end

    tag_matches: assert property (@(posedge clk) disable iff (!rstn)
        div_en_out |-> (div_resp.addr == exp_addr))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %s: tag expected %0d actual %0d", test_name, exp_addr, div_resp.addr);
        end

    latency_matches: assert property (@(posedge clk) disable iff (!rstn)
        div_en_out |-> (edge_cnt == exp_lat))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %s: latency expected %0d actual %0d", test_name, exp_lat, edge_cnt);
        end

    resp_zero_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        (!got_result && !div_en_out) |-> (div_resp == '0))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %s: response expected %010h actual %010h", test_name, 37'h0, div_resp);
        end

    quiet_when_idle: assert property (@(posedge clk) disable iff (!rstn)
        !in_flight |-> (!div_en_out && !stall_because_div))
        else begin
            err_cnt = err_cnt + 1;
            $display("%s: done pulse or stall seen with no division in flight", test_name);
        end

    single_pulse: assert property (@(posedge clk) disable iff (!rstn)
        div_en_out |=> !div_en_out)
        else begin
            err_cnt = err_cnt + 1;
            $display("%s: div_en_out stayed high for more than one cycle", test_name);
        end

    stall_while_busy: assert property (@(posedge clk) disable iff (!rstn)
        (in_flight && !div_en_out) |-> stall_because_div)
        else begin
            err_cnt = err_cnt + 1;
            $display("%s: stall_because_div dropped while the division was running", test_name);
        end

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = err_cnt;
        test_req_base = req_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("%-10s finished: %0d requests, %0d errors", test_name, req_cnt - test_req_base,
                 err_cnt - test_err_base);
    endtask

    task automatic send_req(input div_pkg::data_t a, input div_pkg::data_t b, input logic sgn,
                            input logic rem);
        div_pkg::div_req_t r;
        logic [31:0]       rnd;
        rnd         = $random(seed);
        r.rem_sel   = rem;
        r.is_signed = sgn;
        r.dividend  = a;
        r.divisor   = b;
        r.addr      = rnd[4:0];
        @(posedge clk);
        div_req   <= r;
        div_en_in <= 1'b1;
        @(posedge clk);
        div_en_in <= 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!div_en_out && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        if (!div_en_out) begin
            $display("Timeout: no div_en_out within 40 cycles in test %s", test_name);
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            req_cnt++;
        end
    endtask

    // Quotient and remainder of the same operands.
    task automatic check_div(input div_pkg::data_t a, input div_pkg::data_t b, input logic sgn);
        for (int rem = 0; rem < 2; rem++) begin
            send_req(a, b, sgn, rem[0]);
            wait_done();
        end
    endtask

    initial begin
        logic [31:0]    ra;
        logic [31:0]    rb;
        logic [31:0]    rs;
        div_pkg::data_t edge_vals [3];
        div_pkg::data_t sign_vals [4];
        seed      = 28713;
        err_cnt   = 0;
        req_cnt   = 0;
        test_cnt  = 0;
        test_name = "reset";
        rstn      = 1'b0;
        div_en_in = 1'b0;
        div_req   = '0;
        edge_vals = '{32'h0, 32'h1, 32'hffff_ffff};
        sign_vals = '{32'd1000, 32'hffff_fc18, 32'd7, 32'hffff_fff9};
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        begin_test("reset");
        repeat (4) @(posedge clk);
        end_test();

        begin_test("unsigned");
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                check_div(edge_vals[i], edge_vals[j], 1'b0);
            end
        end
        for (int n = 0; n < 16; n++) begin
            ra = $random(seed);
            rb = $random(seed);
            rs = $random(seed);
            check_div(ra, rb >> rs[4:0], 1'b0);
        end
        end_test();

        begin_test("signed");
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                check_div(sign_vals[i], sign_vals[j], 1'b1);
            end
        end
        check_div(32'h8000_0000, 32'h1, 1'b1);
        check_div(32'h8000_0000, 32'hffff_ffff, 1'b1);
        for (int n = 0; n < 8; n++) begin
            ra = $random(seed);
            rb = $random(seed);
            rs = $random(seed);
            check_div(ra, $signed(rb) >>> rs[4:0], 1'b1);
        end
        end_test();

        begin_test("short_path");
        check_div(32'd12345, 32'h0, 1'b0);
        check_div(32'h8000_0000, 32'h0, 1'b1);
        check_div(32'hffff_fff0, 32'h0, 1'b1);
        check_div(32'd5, 32'd64, 1'b0);
        check_div(32'd0, 32'd3, 1'b0);
        check_div(32'hffff_fffb, 32'd64, 1'b1);
        end_test();

        begin_test("iterative");
        check_div(32'hffff_ffff, 32'h1, 1'b0);
        check_div(32'h1234_5678, 32'd3, 1'b0);
        check_div(32'h8000_0000, 32'd7, 1'b1);
        check_div(32'hffff_ff00, 32'hffff_fffd, 1'b1);
        end_test();

        // A strobe that lands in the middle of a long division must leave no trace.
        begin_test("tag_ignore");
        send_req(32'hffff_ffff, 32'd3, 1'b0, 1'b0);
        repeat (3) @(posedge clk);
        div_req.dividend <= 32'd99;
        div_req.divisor  <= 32'd5;
        div_req.addr     <= ~div_req.addr;
        div_en_in        <= 1'b1;
        @(posedge clk);
        div_en_in <= 1'b0;
        wait_done();
        repeat (6) @(posedge clk);
        end_test();

        $display("tests %0d, requests %0d, errors %0d", test_cnt, req_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hdl/div_pkg.sv
hdl/div_operand_prep.sv
hdl/div_control.sv
hdl/div_shift_subtract.sv
hdl/div_result_fix.sv
hdl/div_unit.sv
test/div_unit_tb.sv

// File: run.sh
#!/bin/sh
# Builds the divider testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module div_unit_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdiv_unit_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
